/* sources.f */
source/mipsPkg.sv
source/alu.sv
source/registerFile.sv
source/datapath.sv
source/controlFsm.sv
source/mipsCore.sv
verification/programMemory.sv
verification/mipsCoreTb.sv

/* verification/mipsCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCoreTb;
   import mipsPkg::*;

   localparam int          halfPeriod  = 4;
   localparam int          period      = 2 * halfPeriod;
   localparam int          resetCycles = 4;
   localparam int          memDepth    = 256;
   localparam logic [31:0] seed        = 32'hcf3556ca;
   localparam logic [31:0] dataBase    = 32'h200;   // program lives below this
   localparam logic [31:0] markerAddr  = 32'h3f0;
   localparam logic [31:0] loopAddr    = 32'h74;    // final self-jump
   localparam int          progLength  = 30;
   localparam int          storeCount  = 9;
   localparam int          maxCpi      = 5;
   localparam int          loopRepeats = 3;
   localparam int          timeoutCycles =
      resetCycles + 2 * (progLength * maxCpi + loopRepeats * 3);

   logic                 clk   = 1'b0;
   logic                 reset = 1'b1;
   logic [dataWidth-1:0] memData;
   logic [dataWidth-1:0] adr;
   logic [dataWidth-1:0] writeData;
   logic                 memRead;
   logic                 memWrite;

   logic [31:0] dataWord;
   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] expAdrQ[$];
   logic [31:0] expDataQ[$];
   logic [31:0] expAdr;
   logic [31:0] expData;
   int          storesSeen  = 0;
   int          loopFetches = 0;
   int          sinceFetch  = 0;
   logic        fetchSeen   = 1'b0;
   opcodeT      lastOp;

   mipsCore dut0 (
      .clk      (clk),
      .reset    (reset),
      .memData  (memData),
      .memRead  (memRead),
      .memWrite (memWrite),
      .adr      (adr),
      .writeData(writeData)
   );

   programMemory #(.depth(memDepth)) mem0 (
      .clk      (clk),
      .memWrite (memWrite),
      .adr      (adr),
      .writeData(writeData),
      .memData  (memData)
   );

   always #halfPeriod clk = ~clk;

   // --------------------------------------------------
   // error reporting
   // --------------------------------------------------
   task automatic abortRun();
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic reportMismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
      abortRun();
   endtask

   // --------------------------------------------------
   // instruction encoders and reference rules
   // --------------------------------------------------
   function automatic instrT rType(input int rs, input int rt, input int rd,
                                   input logic [5:0] fn);
      return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic instrT iType(input opcodeT op, input int rs, input int rt,
                                   input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic instrT jType(input logic [31:0] target);
      return {opJ, target[27:2]};
   endfunction

   function automatic logic [31:0] signExt16(input logic [15:0] value);
      return {{16{value[15]}}, value};
   endfunction

   // fetch to fetch distance per opcode class
   function automatic int cyclesPerInstr(input opcodeT op);
      case (op)
         opLw:                              return 5;
         opSb, opSh, opRtype, opAddi, opAndi: return 4;
         opBeq, opBne, opJ:                 return 3;
         default:                           return 2;
      endcase
   endfunction

   task automatic expectStore(input logic [31:0] address, input logic [31:0] data);
      expAdrQ.push_back(address);
      expDataQ.push_back(data);
   endtask

   // --------------------------------------------------
   // program and expected stores
   // --------------------------------------------------
   task automatic loadProgram();
      instrT prog[$];
      prog.push_back(iType(opLw, 0, 1, 16'h0200));      // 00
      prog.push_back(iType(opLw, 0, 2, 16'h0204));
      prog.push_back(iType(opLw, 0, 3, 16'h0208));
      prog.push_back(rType(1, 2, 4, functAdd));         // 0c
      prog.push_back(iType(opSh, 0, 4, 16'h0300));
      prog.push_back(rType(1, 3, 5, functSub));
      prog.push_back(iType(opSb, 0, 5, 16'h0304));
      prog.push_back(rType(2, 3, 6, functOr));          // 1c
      prog.push_back(iType(opSh, 0, 6, 16'h0308));
      prog.push_back(iType(opAddi, 1, 7, opB[31:16]));
      prog.push_back(iType(opSh, 0, 7, 16'h030c));
      prog.push_back(iType(opAndi, 2, 8, opB[15:0]));   // 2c
      prog.push_back(iType(opSb, 0, 8, 16'h0310));
      prog.push_back(rType(1, 0, 9, functAdd));         // $9 = $1
      prog.push_back(iType(opBeq, 1, 9, 16'd1));        // 38 taken
      prog.push_back(iType(opSh, 0, 4, markerAddr[15:0]));
      prog.push_back(iType(opSb, 0, 1, 16'h0314));      // 40
      prog.push_back(iType(opAddi, 0, 10, 16'd1));
      prog.push_back(iType(opBeq, 10, 0, 16'd2));       // 48 not taken
      prog.push_back(iType(opSh, 0, 10, 16'h0318));
      prog.push_back(jType(32'h58));                    // 50 over marker
      prog.push_back(iType(opSh, 0, 4, markerAddr[15:0]));
      prog.push_back(iType(opBne, 1, 9, 16'd2));        // 58 not taken
      prog.push_back(iType(opSb, 0, 5, 16'h031c));
      prog.push_back(jType(32'h68));
      prog.push_back(iType(opSh, 0, 4, markerAddr[15:0]));
      prog.push_back(iType(opBne, 10, 0, 16'd1));       // 68 taken
      prog.push_back(iType(opSh, 0, 4, markerAddr[15:0]));
      prog.push_back(iType(opSh, 0, 6, 16'h0320));      // 70
      prog.push_back(jType(loopAddr));
      for (int i = 0; i < memDepth; i++)
         mem0.loadWord(i, 32'hfeed0000 | (i << 2));     // byte address in the low bits
      foreach (prog[i])
         mem0.loadWord(i, prog[i]);
      mem0.loadWord(dataBase >> 2, dataWord);
      mem0.loadWord((dataBase >> 2) + 1, opA);
      mem0.loadWord((dataBase >> 2) + 2, opB);
   endtask

   task automatic buildExpected();
      logic [31:0] sum;
      logic [31:0] diff;
      logic [31:0] orValue;
      logic [31:0] addiValue;
      logic [31:0] andiValue;
      sum       = dataWord + opA;
      diff      = dataWord - opB;
      orValue   = opA | opB;
      addiValue = dataWord + signExt16(opB[31:16]);
      andiValue = opA & signExt16(opB[15:0]);
      // sh keeps 16 bits, sb keeps 8, both zero-extended
      expectStore(32'h300, {16'h0, sum[15:0]});
      expectStore(32'h304, {24'h0, diff[7:0]});
      expectStore(32'h308, {16'h0, orValue[15:0]});
      expectStore(32'h30c, {16'h0, addiValue[15:0]});
      expectStore(32'h310, {24'h0, andiValue[7:0]});
      expectStore(32'h314, {24'h0, dataWord[7:0]});
      expectStore(32'h318, 32'h1);
      expectStore(32'h31c, {24'h0, diff[7:0]});
      expectStore(32'h320, {16'h0, orValue[15:0]});
   endtask

   // --------------------------------------------------
   // assertions
   // --------------------------------------------------
   assert property (@(posedge clk) $fell(reset) |-> memRead)
      else reportMismatch("memRead", $sampled(memRead), 32'd1);
   assert property (@(posedge clk) $fell(reset) |-> !memWrite)
      else reportMismatch("memWrite", $sampled(memWrite), 32'd0);
   assert property (@(posedge clk) $fell(reset) |-> adr == '0)
      else reportMismatch("adr", $sampled(adr), 32'd0);

   // skipped paths hold the only marker stores
   assert property (@(posedge clk) disable iff (reset) memWrite |-> adr != markerAddr)
   else
   begin
      $display("store to marker address %h at %0t, a skipped path ran", markerAddr, $time);
      abortRun();
   end

   always @(posedge clk)
   begin
      if (!reset)
      begin
         if (memWrite)
         begin
            if (expAdrQ.size() == 0)
            begin
               $display("store to %h at %0t after the last expected store", adr, $time);
               abortRun();
            end
            else
            begin
               expAdr  = expAdrQ.pop_front();
               expData = expDataQ.pop_front();
               assert (adr == expAdr)
                  else reportMismatch("adr", adr, expAdr);
               assert (writeData == expData)
                  else reportMismatch("writeData", writeData, expData);
               storesSeen++;
            end
         end
         sinceFetch++;
         if (memRead && adr < dataBase)   // loads only touch the data area
         begin
            if (fetchSeen)
            begin
               assert (sinceFetch == cyclesPerInstr(lastOp))
                  else reportMismatch("fetch spacing", sinceFetch, cyclesPerInstr(lastOp));
            end
            if (storesSeen == storeCount && adr == loopAddr)
               loopFetches++;
            fetchSeen  = 1'b1;
            sinceFetch = 0;
            lastOp     = memData[31:26];
         end
      end
   end

   // --------------------------------------------------
   // main sequence and watchdog
   // --------------------------------------------------
   initial
   begin
      void'($urandom(seed));
      dataWord = $urandom();
      opA      = $urandom();
      opB      = $urandom();
      loadProgram();
      buildExpected();
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      wait (storesSeen == storeCount && loopFetches >= loopRepeats);
      @(negedge clk);
      $display("Verification passed");
      $finish;
   end

   initial
   begin
      #(timeoutCycles * period);
      $display("TIMEOUT at %0t: %0d of %0d expected stores seen, %0d loop fetches",
               $time, storesSeen, storeCount, loopFetches);
      abortRun();
   end

endmodule

`default_nettype wire

/* verification/programMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module programMemory
#(
   parameter int depth = 256
)
(
   input  wire logic                          clk,
   input  wire logic                          memWrite,
   input  wire logic [mipsPkg::dataWidth-1:0] adr,
   input  wire logic [mipsPkg::dataWidth-1:0] writeData,
   output logic      [mipsPkg::dataWidth-1:0] memData
);
   import mipsPkg::*;

   localparam int indexBits = $clog2(depth);

   logic [dataWidth-1:0] words [0:depth-1];

   // byte address in, word index used
   assign memData = words[adr[indexBits+1:2]];

   // store lands at the rising edge
   always @(posedge clk)
   begin
      if (memWrite)
         words[adr[indexBits+1:2]] <= writeData;
   end

   // --------------------------------------------------
   // preload from the testbench
   // --------------------------------------------------
   task automatic loadWord(input int index, input logic [dataWidth-1:0] value);
      words[index] = value;
   endtask

endmodule

`default_nettype wire

/* source/mipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCore
(
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic [mipsPkg::dataWidth-1:0] memData,
   output logic                              memRead,
   output logic                              memWrite,
   output logic      [mipsPkg::dataWidth-1:0] adr,
   output logic      [mipsPkg::dataWidth-1:0] writeData
);
   import mipsPkg::*;

   // controller to datapath
   logic      irWrite;
   logic      pcEnable;
   logic      regWrite;
   logic      regDstRd;
   logic      memToReg;
   logic      iOrD;
   logic      srcASel;
   srcBSelT   srcBSel;
   pcSrcT     pcSrc;
   aluOpT     aluOp;
   storeSizeT storeSize;

   // datapath back to controller
   opcodeT     opcode;
   logic [5:0] funct;
   logic       zero;

   controlFsm control0 (
      .clk      (clk),
      .reset    (reset),
      .opcode   (opcode),
      .funct    (funct),
      .zero     (zero),
      .memRead  (memRead),
      .memWrite (memWrite),
      .irWrite  (irWrite),
      .pcEnable (pcEnable),
      .regWrite (regWrite),
      .regDstRd (regDstRd),
      .memToReg (memToReg),
      .iOrD     (iOrD),
      .srcASel  (srcASel),
      .srcBSel  (srcBSel),
      .pcSrc    (pcSrc),
      .aluOp    (aluOp),
      .storeSize(storeSize)
   );

   datapath datapath0 (
      .clk      (clk),
      .reset    (reset),
      .memData  (memData),
      .irWrite  (irWrite),
      .pcEnable (pcEnable),
      .regWrite (regWrite),
      .regDstRd (regDstRd),
      .memToReg (memToReg),
      .iOrD     (iOrD),
      .srcASel  (srcASel),
      .srcBSel  (srcBSel),
      .pcSrc    (pcSrc),
      .aluOp    (aluOp),
      .storeSize(storeSize),
      .opcode   (opcode),
      .funct    (funct),
      .zero     (zero),
      .adr      (adr),
      .writeData(writeData)
   );

endmodule

`default_nettype wire

/* source/controlFsm.sv */
`timescale 1ns/10ps
`default_nettype none

module controlFsm
(
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire mipsPkg::opcodeT    opcode,
   input  wire logic [5:0]         funct,
   input  wire logic               zero,
   output logic                    memRead,
   output logic                    memWrite,
   output logic                    irWrite,
   output logic                    pcEnable,
   output logic                    regWrite,
   output logic                    regDstRd,
   output logic                    memToReg,
   output logic                    iOrD,
   output logic                    srcASel,
   output mipsPkg::srcBSelT        srcBSel,
   output mipsPkg::pcSrcT          pcSrc,
   output mipsPkg::aluOpT          aluOp,
   output mipsPkg::storeSizeT      storeSize
);
   import mipsPkg::*;

   cpuStateT state;
   cpuStateT nextState;

   logic pcWrite;   // unconditional pc load
   logic branchEq;
   logic branchNe;

   // --------------------------------------------------
   // state register and next state
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         state <= fetch;
      else
         state <= nextState;
   end

   always_comb
   begin
      nextState = fetch;   // every terminal state returns here
      case (state)
         fetch:
            nextState = decode;
         decode:
         begin
            case (opcode)
               opLw, opSb, opSh: nextState = memAddr;
               opRtype:          nextState = rTypeExec;
               opBeq:            nextState = branchEqExec;
               opBne:            nextState = branchNeExec;
               opJ:              nextState = jumpExec;
               opAddi:           nextState = immAddExec;
               opAndi:           nextState = immAndExec;
               default:          nextState = fetch;   // unknown op, 2 cycles
            endcase
         end
         memAddr:
         begin
            case (opcode)
               opLw:    nextState = loadRead;
               opSb:    nextState = storeByte;
               opSh:    nextState = storeHalf;
               default: nextState = fetch;
            endcase
         end
         loadRead:   nextState = loadWrite;
         rTypeExec:  nextState = rTypeWrite;
         immAddExec: nextState = immWrite;
         immAndExec: nextState = immWrite;
         default:    nextState = fetch;
      endcase
   end

   // --------------------------------------------------
   // control decode
   // --------------------------------------------------
   always_comb
   begin
      memRead   = 1'b0;
      memWrite  = 1'b0;
      irWrite   = 1'b0;
      pcWrite   = 1'b0;
      branchEq  = 1'b0;
      branchNe  = 1'b0;
      regWrite  = 1'b0;
      regDstRd  = 1'b0;
      memToReg  = 1'b0;
      iOrD      = 1'b0;
      srcASel   = 1'b0;
      srcBSel   = srcBReg;
      pcSrc     = pcSrcAlu;
      aluOp     = aluAdd;
      storeSize = storeWord;
      case (state)
         fetch:
         begin
            memRead = 1'b1;
            irWrite = 1'b1;
            srcBSel = srcBFour;   // pc + 4
            pcWrite = 1'b1;
         end
         decode:
            srcBSel = srcBBranchOff;   // branch target into aluOut
         memAddr, immAddExec:
         begin
            srcASel = 1'b1;
            srcBSel = srcBSignImm;
         end
         immAndExec:
         begin
            srcASel = 1'b1;
            srcBSel = srcBSignImm;
            aluOp   = aluAnd;
         end
         loadRead:
         begin
            memRead = 1'b1;
            iOrD    = 1'b1;
         end
         loadWrite:
         begin
            regWrite = 1'b1;
            memToReg = 1'b1;
         end
         storeByte:
         begin
            memWrite  = 1'b1;
            iOrD      = 1'b1;
            storeSize = storeByteOnly;
         end
         storeHalf:
         begin
            memWrite  = 1'b1;
            iOrD      = 1'b1;
            storeSize = storeHalfWord;
         end
         rTypeExec:
         begin
            srcASel = 1'b1;
            case (funct)
               functSub: aluOp = aluSub;
               functOr:  aluOp = aluOr;
               default:  aluOp = aluAdd;   // add and anything unknown
            endcase
         end
         rTypeWrite:
         begin
            regWrite = 1'b1;
            regDstRd = 1'b1;
         end
         branchEqExec, branchNeExec:
         begin
            srcASel  = 1'b1;   // compare A against B
            aluOp    = aluSub;
            pcSrc    = pcSrcAluOut;
            branchEq = (state == branchEqExec);
            branchNe = (state == branchNeExec);
         end
         jumpExec:
         begin
            pcWrite = 1'b1;
            pcSrc   = pcSrcJump;
         end
         immWrite:
            regWrite = 1'b1;   // rt destination
         default:
            ;
      endcase
   end

   assign pcEnable = pcWrite | (branchEq & zero) | (branchNe & ~zero);

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite));

   assert property (@(posedge clk) disable iff (reset)
      state inside {fetch, decode, memAddr, loadRead, loadWrite, storeByte, storeHalf,
                    rTypeExec, rTypeWrite, branchEqExec, branchNeExec, jumpExec,
                    immAddExec, immAndExec, immWrite});

   // instruction register only changes on a fetch
   assert property (@(posedge clk) disable iff (reset) irWrite |-> state == fetch);

endmodule

`default_nettype wire

/* source/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath
(
   input  wire logic                          clk,
   input  wire logic                          reset,
   input  wire logic [mipsPkg::dataWidth-1:0] memData,
   input  wire logic                          irWrite,
   input  wire logic                          pcEnable,
   input  wire logic                          regWrite,
   input  wire logic                          regDstRd,
   input  wire logic                          memToReg,
   input  wire logic                          iOrD,
   input  wire logic                          srcASel,
   input  wire mipsPkg::srcBSelT              srcBSel,
   input  wire mipsPkg::pcSrcT                pcSrc,
   input  wire mipsPkg::aluOpT                aluOp,
   input  wire mipsPkg::storeSizeT            storeSize,
   output mipsPkg::opcodeT                    opcode,
   output logic      [5:0]                    funct,
   output logic                               zero,
   output logic      [mipsPkg::dataWidth-1:0] adr,
   output logic      [mipsPkg::dataWidth-1:0] writeData
);
   import mipsPkg::*;

   instrT                   instr;
   logic [dataWidth-1:0]    pc;
   logic [dataWidth-1:0]    nextPc;
   logic [dataWidth-1:0]    memDataReg;
   logic [dataWidth-1:0]    regA;
   logic [dataWidth-1:0]    regB;
   logic [dataWidth-1:0]    aluOut;
   logic [dataWidth-1:0]    aluResult;
   logic [dataWidth-1:0]    srcA;
   logic [dataWidth-1:0]    srcB;
   logic [dataWidth-1:0]    signImm;
   logic [dataWidth-1:0]    branchOff;
   logic [dataWidth-1:0]    jumpTarget;
   logic [dataWidth-1:0]    readData1;
   logic [dataWidth-1:0]    readData2;
   logic [dataWidth-1:0]    writeBackData;
   logic [regAddrWidth-1:0] writeAddr;

   // --------------------------------------------------
   // state registers
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '0;
      else if (pcEnable)
         pc <= nextPc;
   end

   always_ff @(posedge clk)
   begin
      if (irWrite)
         instr <= memData;
   end

   // loaded every cycle, controller picks when they matter
   always_ff @(posedge clk)
   begin
      memDataReg <= memData;
      regA       <= readData1;
      regB       <= readData2;
      aluOut     <= aluResult;
   end

   // --------------------------------------------------
   // instruction fields and immediates
   // --------------------------------------------------
   assign opcode     = instr[31:26];
   assign funct      = instr[5:0];
   assign signImm    = {{(dataWidth-16){instr[15]}}, instr[15:0]};
   assign branchOff  = {signImm[dataWidth-3:0], 2'b00};
   assign jumpTarget = {pc[dataWidth-1:dataWidth-4], instr[25:0], 2'b00};

   // rd for r-type, rt otherwise
   assign writeAddr     = regDstRd ? instr[15:11] : instr[20:16];
   assign writeBackData = memToReg ? memDataReg : aluOut;

   registerFile regFile0 (
      .clk      (clk),
      .reset    (reset),
      .regWrite (regWrite),
      .readAddr1(instr[25:21]),
      .readAddr2(instr[20:16]),
      .writeAddr(writeAddr),
      .writeData(writeBackData),
      .readData1(readData1),
      .readData2(readData2)
   );

   // --------------------------------------------------
   // operand and pc muxes
   // --------------------------------------------------
   assign srcA = srcASel ? regA : pc;

   always_comb
   begin
      case (srcBSel)
         srcBFour:      srcB = dataWidth'(4);
         srcBSignImm:   srcB = signImm;
         srcBBranchOff: srcB = branchOff;
         default:       srcB = regB;
      endcase
   end

   alu alu0 (
      .a     (srcA),
      .b     (srcB),
      .aluOp (aluOp),
      .result(aluResult)
   );

   assign zero = (aluResult == '0);

   always_comb
   begin
      case (pcSrc)
         pcSrcAluOut: nextPc = aluOut;
         pcSrcJump:   nextPc = jumpTarget;
         default:     nextPc = aluResult;
      endcase
   end

   assign adr = iOrD ? aluOut : pc;   // data access or fetch

   // partial stores send the low bits, zero-extended
   always_comb
   begin
      case (storeSize)
         storeHalfWord: writeData = {{(dataWidth-16){1'b0}}, regB[15:0]};
         storeByteOnly: writeData = {{(dataWidth-8){1'b0}}, regB[7:0]};
         default:       writeData = regB;
      endcase
   end

   assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile
(
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire logic                             regWrite,
   input  wire logic [mipsPkg::regAddrWidth-1:0] readAddr1,
   input  wire logic [mipsPkg::regAddrWidth-1:0] readAddr2,
   input  wire logic [mipsPkg::regAddrWidth-1:0] writeAddr,
   input  wire logic [mipsPkg::dataWidth-1:0]    writeData,
   output logic      [mipsPkg::dataWidth-1:0]    readData1,
   output logic      [mipsPkg::dataWidth-1:0]    readData2
);
   import mipsPkg::*;

   logic [dataWidth-1:0] regs [0:regCount-1];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < regCount; i++)
            regs[i] <= '0;   // whole file starts cleared
      end
      else if (regWrite && writeAddr != '0)
         regs[writeAddr] <= writeData;
   end

   // register zero hardwired
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

   // program never targets $0
   assert property (@(posedge clk) disable iff (reset) regWrite |-> writeAddr != '0);

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu
(
   input  wire logic [mipsPkg::dataWidth-1:0] a,
   input  wire logic [mipsPkg::dataWidth-1:0] b,
   input  wire mipsPkg::aluOpT                aluOp,
   output logic      [mipsPkg::dataWidth-1:0] result
);
   import mipsPkg::*;

   // purely combinational, zero flag is built outside
   always_comb
   begin
      case (aluOp)
         aluSub:  result = a - b;   // also the branch compare
         aluAnd:  result = a & b;
         aluOr:   result = a | b;
         default: result = a + b;
      endcase
   end

endmodule

`default_nettype wire

/* source/mipsPkg.sv */
`default_nettype none

package mipsPkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 5;
   localparam int regCount     = 1 << regAddrWidth;  // 32 entries

   typedef logic [dataWidth-1:0] instrT;
   typedef logic [5:0]           opcodeT;

   // --------------------------------------------------
   // opcodes and function codes
   // --------------------------------------------------
   localparam opcodeT opLw    = 6'b100011;
   localparam opcodeT opSb    = 6'b101000;
   localparam opcodeT opSh    = 6'b101001;
   localparam opcodeT opRtype = 6'b000000;
   localparam opcodeT opBeq   = 6'b000100;
   localparam opcodeT opBne   = 6'b000101;
   localparam opcodeT opJ     = 6'b000010;
   localparam opcodeT opAddi  = 6'b001000;
   localparam opcodeT opAndi  = 6'b001100;

   // r-type funct field
   localparam logic [5:0] functAdd = 6'b100000;
   localparam logic [5:0] functSub = 6'b100010;
   localparam logic [5:0] functOr  = 6'b100101;

   // --------------------------------------------------
   // control encodings
   // --------------------------------------------------
   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr
   } aluOpT;

   // one state per cycle, see controller
   typedef enum logic [3:0] {
      fetch,
      decode,
      memAddr,
      loadRead,
      loadWrite,
      storeByte,
      storeHalf,
      rTypeExec,
      rTypeWrite,
      branchEqExec,
      branchNeExec,
      jumpExec,
      immAddExec,
      immAndExec,
      immWrite
   } cpuStateT;

   // low part of B is zero-extended for partial stores
   typedef enum logic [1:0] {
      storeWord,
      storeHalfWord,
      storeByteOnly
   } storeSizeT;

   typedef enum logic [1:0] {
      srcBReg,        // B register
      srcBFour,       // constant four
      srcBSignImm,
      srcBBranchOff   // sign imm << 2
   } srcBSelT;

   typedef enum logic [1:0] {
      pcSrcAlu,       // pc + 4 straight from alu
      pcSrcAluOut,    // branch target held from decode
      pcSrcJump
   } pcSrcT;

endpackage

`default_nettype wire
